//--- hdl/nbhd_cfg.svh
// Neighborhood attention configuration
// Sizes shared by the token path and the score unit

`ifndef NBHD_CFG_SVH
`define NBHD_CFG_SVH

// One feature vector, four signed lanes
`define NBHD_FEAT_W 32
`define NBHD_LANE_W 8

// Tag layout, group in the high bits and position in the low bits
`define NBHD_TAG_W 16
`define NBHD_IDX_W 4

// 3x3 window
`define NBHD_N 9
// Centre token supplies the query
`define NBHD_CENTER 4

`endif

//--- hdl/nbhd_token_pkg.sv
// Token types for the neighborhood attention front end
// Feature vectors, tags and the assembler phase

`include "nbhd_cfg.svh"

package nbhd_token_pkg;

  // Raw feature vector as it arrives
  typedef logic [`NBHD_FEAT_W-1:0] feat_t;

  // Full tag and its two fields
  typedef logic [`NBHD_TAG_W-1:0] tag_t;
  typedef logic [`NBHD_IDX_W-1:0] pos_t;
  typedef logic [`NBHD_TAG_W-`NBHD_IDX_W-1:0] group_t;

  // One bit per window position
  typedef logic [`NBHD_N-1:0] slot_mask_t;

  // Assembler phase
  typedef enum logic [1:0] {
    COLLECT  = 2'd0,
    HOLD     = 2'd1,
    COOLDOWN = 2'd2
  } asm_phase_e;

endpackage

//--- hdl/nbhd_score_pkg.sv
// Score types for the neighborhood attention front end
// Lanes, dot-product results and the score unit state

`include "nbhd_cfg.svh"

package nbhd_score_pkg;

  // Lanes per feature vector
  localparam int NUM_LANES = `NBHD_FEAT_W / `NBHD_LANE_W;

  // 8x8 signed products summed over four lanes need two guard bits
  localparam int SCORE_W = 2 * `NBHD_LANE_W + 2;

  typedef logic signed [`NBHD_LANE_W-1:0] lane_t;
  typedef logic signed [SCORE_W-1:0] score_t;

  // Score unit state
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SCAN = 2'd1,
    DONE = 2'd2
  } score_state_e;

endpackage

//--- hdl/nbhd_bundle_assembler.sv
// Bundle assembler for a 3x3 neighborhood
// Collects nine tagged tokens of one group and holds the bundle until consumed

`timescale 1ns/1ns

`include "nbhd_cfg.svh"

module nbhd_bundle_assembler (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      en,
  input  logic                                      feat_valid,
  output logic                                      feat_ready,
  input  nbhd_token_pkg::feat_t                     feat_vec,
  input  nbhd_token_pkg::tag_t                      feat_tag,
  output logic                                      bundle_valid,
  input  logic                                      bundle_ready,
  output nbhd_token_pkg::feat_t [`NBHD_N-1:0]       kv_bus,
  output nbhd_token_pkg::feat_t                     q_vec,
  output nbhd_token_pkg::group_t                    bundle_group
);

  import nbhd_token_pkg::*;

  asm_phase_e           phase;
  slot_mask_t           mask;
  slot_mask_t           mask_next;
  group_t               cur_group;
  feat_t [`NBHD_N-1:0]  slot;

  group_t tok_group;
  pos_t   tok_pos;
  logic   pos_ok;
  logic   mask_full;
  logic   accept;
  logic   take;
  logic   flush;
  logic   consume;

  // ----------------------------------------------------------
  // Tag decode and handshakes
  // ----------------------------------------------------------
  assign tok_group = feat_tag[`NBHD_TAG_W-1:`NBHD_IDX_W];
  assign tok_pos   = feat_tag[`NBHD_IDX_W-1:0];
  assign pos_ok    = (tok_pos < pos_t'(`NBHD_N));
  assign mask_full = &mask;

  // Phase COLLECT already excludes the cooldown cycle after a consume.
  // A full mask also closes the input until the bundle is raised
  assign feat_ready = en && !rst && (phase == COLLECT) && !mask_full;

  assign accept  = en && feat_valid && feat_ready;
  // Out-of-window positions are taken from the bus but change nothing
  assign take    = accept && pos_ok;
  // Token from another group drops the partial bundle
  assign flush   = take && (mask != '0) && (tok_group != cur_group);
  assign consume = en && bundle_valid && bundle_ready;

  // New token lands in the cleared set on a flush
  assign mask_next = (flush ? slot_mask_t'(0) : mask) | (slot_mask_t'(1) << tok_pos);

  // ----------------------------------------------------------
  // Phase, mask and group tracking
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= COLLECT;
      mask      <= '0;
      cur_group <= '0;
    end else if (en) begin
      if (consume) begin
        // Consume wins, one stall cycle follows
        phase <= COOLDOWN;
        mask  <= '0;
      end else if (phase == COOLDOWN) begin
        phase <= COLLECT;
      end else if (phase == HOLD) begin
        // Back-pressure, keep the bundle up
        phase <= HOLD;
      end else begin
        // Raise one cycle after the mask fills
        if (mask_full) begin
          phase <= HOLD;
        end
        if (take) begin
          mask      <= mask_next;
          cur_group <= tok_group;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Slot registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (take) begin
      for (int i = 0; i < `NBHD_N; i++) begin
        if (flush) begin
          slot[i] <= '0;
        end
        // Later token at the same position overwrites
        if (tok_pos == pos_t'(i)) begin
          slot[i] <= feat_vec;
        end
      end
    end
  end

  assign bundle_valid = (phase == HOLD);
  assign kv_bus       = slot;
  assign q_vec        = slot[`NBHD_CENTER];
  assign bundle_group = cur_group;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Bundle holds steady until the score unit takes it
  a_bundle_stable : assert property (
    @(posedge clk) disable iff (rst)
    bundle_valid && !consume |=> bundle_valid && $stable(kv_bus) && $stable(bundle_group)
  );

  // Exactly one stall cycle after each consume
  a_cooldown : assert property (
    @(posedge clk) disable iff (rst)
    consume |=> !feat_ready
  );

endmodule

//--- hdl/nbhd_score_unit.sv
// Score unit for the neighborhood attention front end
// Scans nine keys against the centre query and reports the best match

`timescale 1ns/1ns

`include "nbhd_cfg.svh"

module nbhd_score_unit (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 bundle_valid,
  output logic                                 bundle_ready,
  input  nbhd_token_pkg::feat_t [`NBHD_N-1:0]  kv_bus,
  input  nbhd_token_pkg::feat_t                q_vec,
  input  nbhd_token_pkg::group_t               bundle_group,
  output logic                                 result_valid,
  output nbhd_token_pkg::pos_t                 result_pos,
  output nbhd_score_pkg::score_t               result_score,
  output nbhd_token_pkg::group_t               result_group
);

  import nbhd_token_pkg::*;
  import nbhd_score_pkg::*;

  score_state_e state;
  pos_t         cnt;
  pos_t         best_pos;
  score_t       best_score;
  score_t       cur_score;
  feat_t        key;
  logic         better;
  logic         last;

  // ----------------------------------------------------------
  // Dot product of the selected key with the query
  // ----------------------------------------------------------
  always_comb begin
    lane_t q_lane;
    lane_t k_lane;
    key       = kv_bus[cnt];
    cur_score = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      q_lane    = lane_t'(q_vec[l*`NBHD_LANE_W +: `NBHD_LANE_W]);
      k_lane    = lane_t'(key[l*`NBHD_LANE_W +: `NBHD_LANE_W]);
      // Widen before multiplying so the product keeps its sign
      cur_score = cur_score + score_t'(q_lane) * score_t'(k_lane);
    end
  end

  // First position seeds the best, ties keep the lower position
  assign better = (cnt == '0) || (cur_score > best_score);
  assign last   = (cnt == pos_t'(`NBHD_N - 1));

  // ----------------------------------------------------------
  // Scan FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      cnt          <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (bundle_valid) begin
            state <= SCAN;
            cnt   <= '0;
          end
        end
        SCAN: begin
          if (last) begin
            state        <= DONE;
            result_valid <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DONE: begin
          // Leave once the assembler has dropped the consumed bundle
          if (!bundle_valid) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Running best and result payload
  always_ff @(posedge clk) begin
    if (state == SCAN) begin
      if (better) begin
        best_pos   <= cnt;
        best_score <= cur_score;
      end
      if (last) begin
        result_pos   <= better ? cnt : best_pos;
        result_score <= better ? cur_score : best_score;
        result_group <= bundle_group;
      end
    end
  end

  assign bundle_ready = (state == DONE) && bundle_valid;

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_result_pulse : assert property (
    @(posedge clk) disable iff (rst)
    result_valid |=> !result_valid
  );

  a_cnt_range : assert property (
    @(posedge clk) disable iff (rst)
    cnt <= pos_t'(`NBHD_N - 1)
  );

endmodule

//--- hdl/nbhd_attn_top.sv
// Neighborhood attention front end
// Bundle assembler feeding the query-key score unit

`timescale 1ns/1ns

`include "nbhd_cfg.svh"

module nbhd_attn_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  logic                    feat_valid,
  output logic                    feat_ready,
  input  nbhd_token_pkg::feat_t   feat_vec,
  input  nbhd_token_pkg::tag_t    feat_tag,
  output logic                    result_valid,
  output nbhd_token_pkg::pos_t    result_pos,
  output nbhd_score_pkg::score_t  result_score,
  output nbhd_token_pkg::group_t  result_group
);

  import nbhd_token_pkg::*;

  // Assembler to score unit
  logic                 bundle_valid;
  logic                 bundle_ready;
  feat_t [`NBHD_N-1:0]  kv_bus;
  feat_t                q_vec;
  group_t               bundle_group;

  nbhd_bundle_assembler nbhd_bundle_assembler_i (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .feat_valid   (feat_valid),
    .feat_ready   (feat_ready),
    .feat_vec     (feat_vec),
    .feat_tag     (feat_tag),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .kv_bus       (kv_bus),
    .q_vec        (q_vec),
    .bundle_group (bundle_group)
  );

  // Runs without en, the consume itself is gated in the assembler
  nbhd_score_unit nbhd_score_unit_i (
    .clk          (clk),
    .rst          (rst),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .kv_bus       (kv_bus),
    .q_vec        (q_vec),
    .bundle_group (bundle_group),
    .result_valid (result_valid),
    .result_pos   (result_pos),
    .result_score (result_score),
    .result_group (result_group)
  );

endmodule

//--- verif/nbhd_attn_tb.sv
// Testbench for the neighborhood attention front end
// Token table with a reference model, result checks and a watchdog

`timescale 1ns/1ns

`include "nbhd_cfg.svh"

module nbhd_attn_tb;

  import nbhd_token_pkg::*;
  import nbhd_score_pkg::*;

  localparam int MAX_ROWS      = 64;
  localparam int EN_LOW_CYCLES = 4;
  localparam int LATENCY       = 12;
  localparam int ROW_CYCLES    = 40;

  logic   clk;
  logic   rst;
  logic   en;
  logic   feat_valid;
  logic   feat_ready;
  feat_t  feat_vec;
  tag_t   feat_tag;
  logic   result_valid;
  pos_t   result_pos;
  score_t result_score;
  group_t result_group;

  // Token table
  tag_t        tab_tag [MAX_ROWS];
  feat_t       tab_vec [MAX_ROWS];
  logic        tab_en  [MAX_ROWS];
  logic        tab_res [MAX_ROWS];
  int          n_rows;
  logic        table_ready;
  logic [31:0] rng_state;

  // Reference model state
  feat_t      m_slot [`NBHD_N];
  slot_mask_t m_mask;
  group_t     m_group;

  // Expected results in arrival order
  pos_t   exp_pos_q   [$];
  score_t exp_score_q [$];
  group_t exp_group_q [$];
  int     exp_cycle_q [$];

  int   cycle;
  int   errors;
  int   checks;
  int   results;
  logic consume_d1;
  logic consume_d2;

  nbhd_attn_top nbhd_attn_top_i (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .feat_valid   (feat_valid),
    .feat_ready   (feat_ready),
    .feat_vec     (feat_vec),
    .feat_tag     (feat_tag),
    .result_valid (result_valid),
    .result_pos   (result_pos),
    .result_score (result_score),
    .result_group (result_group)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic tag_t tag_of(input group_t g, input int p);
    return {g, p[`NBHD_IDX_W-1:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_row(input tag_t tag, input feat_t vec, input logic row_en,
                         input logic row_res);
    tab_tag[n_rows] = tag;
    tab_vec[n_rows] = vec;
    tab_en[n_rows]  = row_en;
    tab_res[n_rows] = row_res;
    n_rows++;
  endtask

  task automatic add_rand_row(input tag_t tag, input logic row_res);
    rng_state = lcg_next(rng_state);
    add_row(tag, rng_state, 1'b1, row_res);
  endtask

  task automatic build_table();
    int    order_b [10] = '{3, 7, 0, 5, 3, 8, 1, 4, 6, 2};
    int    order_d [9]  = '{5, 7, 6, 8, 0, 2, 1, 4, 3};
    int    seq_e   [13] = '{0, 9, 1, 2, 15, 3, 4, 12, 5, 6, 7, 10, 8};
    feat_t v;
    n_rows    = 0;
    rng_state = 32'h09bcec69;
    // Nine tokens in order
    for (int p = 0; p < `NBHD_N; p++) add_rand_row(tag_of(12'h011, p), p == `NBHD_N - 1);
    // Shuffled order with position 3 repeated and en low after the first token
    for (int i = 0; i < 10; i++) begin
      add_rand_row(tag_of(12'h022, order_b[i]), i == 9);
      // Foreign group token that would flush group 0x022 if taken
      if (i == 0) add_row(tag_of(12'h0ee, 1), 32'h5a5a5a5a, 1'b0, 1'b0);
    end
    // Five tokens before a new group takes over
    for (int p = 0; p < 5; p++) add_rand_row(tag_of(12'h033, p), 1'b0);
    // New group fills the upper positions first, a kept partial set would complete early
    for (int i = 0; i < 9; i++) add_rand_row(tag_of(12'h044, order_d[i]), i == 8);
    // Out-of-window positions mixed in with one from another group
    for (int i = 0; i < 13; i++) begin
      add_rand_row(tag_of((seq_e[i] == 12) ? 12'h0ff : 12'h055, seq_e[i]), i == 12);
    end
    // Equal best keys at 2 and 6 with mixed-sign lanes
    for (int p = 0; p < `NBHD_N; p++) begin
      if (p == 2 || p == 6) v = 32'h7f807f80;
      else if (p == `NBHD_CENTER) v = 32'h01ff01ff;
      else v = 32'h01010101;
      add_row(tag_of(12'h066, p), v, 1'b1, p == `NBHD_N - 1);
    end
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic int lane_dot(input feat_t a, input feat_t b);
    int sum;
    int la;
    int lb;
    sum = 0;
    for (int l = 0; l < `NBHD_FEAT_W / `NBHD_LANE_W; l++) begin
      la  = int'($signed(a[l*`NBHD_LANE_W +: `NBHD_LANE_W]));
      lb  = int'($signed(b[l*`NBHD_LANE_W +: `NBHD_LANE_W]));
      sum = sum + la * lb;
    end
    return sum;
  endfunction

  task automatic push_expected();
    int best;
    int best_pos;
    int s;
    best     = 0;
    best_pos = 0;
    for (int p = 0; p < `NBHD_N; p++) begin
      s = lane_dot(m_slot[`NBHD_CENTER], m_slot[p]);
      // Strictly greater only so ties keep the lower position
      if (p == 0 || s > best) begin
        best     = s;
        best_pos = p;
      end
    end
    exp_pos_q.push_back(pos_t'(best_pos));
    exp_score_q.push_back(score_t'(best));
    exp_group_q.push_back(m_group);
    exp_cycle_q.push_back(cycle);
  endtask

  task automatic model_accept(input tag_t tag, input feat_t vec);
    pos_t   p;
    group_t g;
    p = tag[`NBHD_IDX_W-1:0];
    g = tag[`NBHD_TAG_W-1:`NBHD_IDX_W];
    // Positions past the window are taken but change nothing
    if (int'(p) < `NBHD_N) begin
      if (m_mask != '0 && g != m_group) begin
        for (int i = 0; i < `NBHD_N; i++) m_slot[i] = '0;
        m_mask = '0;
      end
      m_slot[p] = vec;
      m_mask[p] = 1'b1;
      m_group   = g;
      if (&m_mask) begin
        push_expected();
        m_mask = '0;
      end
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d checks, %0d errors, %0d results", checks, errors, results);
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    int flagged;
    rst         = 1'b1;
    en          = 1'b0;
    feat_valid  = 1'b0;
    feat_vec    = '0;
    feat_tag    = '0;
    m_mask      = '0;
    m_group     = '0;
    table_ready = 1'b0;
    flagged     = 0;
    for (int i = 0; i < `NBHD_N; i++) m_slot[i] = '0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    en  <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      feat_tag   <= tab_tag[r];
      feat_vec   <= tab_vec[r];
      feat_valid <= 1'b1;
      if (!tab_en[r]) begin
        // Frozen input so the token must not be taken
        en <= 1'b0;
        repeat (EN_LOW_CYCLES) begin
          @(posedge clk);
          check_value("feat_ready", 32'(feat_ready), 32'd0);
        end
        en <= 1'b1;
      end else begin
        en <= 1'b1;
        @(posedge clk);
        while (!feat_ready) @(posedge clk);
        model_accept(tab_tag[r], tab_vec[r]);
        if (tab_res[r]) flagged++;
      end
    end
    feat_valid <= 1'b0;
    // Drain outstanding results and the last cooldown
    while (exp_pos_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check_value("result_count", 32'(results), 32'(flagged));
    print_summary();
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // Result and cooldown monitor
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst) begin
      consume_d1 <= 1'b0;
      consume_d2 <= 1'b0;
    end else begin
      // Result cycle is also the consume cycle while en is high
      consume_d1 <= result_valid && en;
      consume_d2 <= consume_d1;
      if (consume_d1) check_value("feat_ready", 32'(feat_ready), 32'd0);
      if (consume_d2 && en) check_value("feat_ready", 32'(feat_ready), 32'd1);
      if (result_valid) begin
        results++;
        if (exp_pos_q.size() == 0) begin
          errors++;
          $display("Result at %0t arrived with no bundle outstanding", $time);
        end else begin
          check_value("result_pos", 32'(result_pos), 32'(exp_pos_q.pop_front()));
          check_value("result_score", 32'(result_score), 32'(exp_score_q.pop_front()));
          check_value("result_group", 32'(result_group), 32'(exp_group_q.pop_front()));
          check_value("result_latency", 32'(cycle - exp_cycle_q.pop_front()), 32'(LATENCY));
        end
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready === 1'b1);
    repeat (n_rows * ROW_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", n_rows * ROW_CYCLES);
    print_summary();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+hdl
hdl/nbhd_token_pkg.sv
hdl/nbhd_score_pkg.sv
hdl/nbhd_bundle_assembler.sv
hdl/nbhd_score_unit.sv
hdl/nbhd_attn_top.sv
verif/nbhd_attn_tb.sv

//--- Makefile
TOP = nbhd_attn_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^SIMULATION PASSED$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module nbhd_attn_top

clean:
	rm -rf obj_dir
